// ==== bench/stimulus_words.txt ====
# columns: data (hex), last, idle wclk cycles before the word, phase
# phase 0 is free flow with random out_ready, phase 1 fills with out_ready low
3c 0 0 0
a5 0 2 0
5a 0 0 0
e1 1 1 0
07 0 3 0
f0 0 0 0
99 0 1 0
42 1 0 0
10 0 0 1
21 0 0 1
32 0 0 1
43 0 0 1
54 0 0 1
65 0 0 1
76 1 0 1
87 0 0 1
98 0 0 1
a9 0 0 1
ba 0 0 1
cb 0 0 1
dc 0 0 1
ed 1 0 1
fe 0 0 1
0f 0 0 1
b3 0 0 1
6d 1 0 1
c4 0 2 0
2b 1 1 0

// ==== bench/tb_cdc_stream_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cdc_stream_bridge;
   import stream_pkg::*;
   import fifo_pkg::*;

   localparam int TIMEOUT_CYCLES = 400;
   localparam int STALL_CYCLES   = 16;
   // out_ready modes
   localparam int READY_RANDOM   = 0;
   localparam int READY_LOW      = 1;
   localparam int READY_HIGH     = 2;
   // with out_ready low only the output register holds a word
   localparam int CONSUMER_HELD  = 1;

   logic        rst;
   logic        wclk;
   logic        rclk;
   logic        in_valid;
   data_t       in_data;
   logic        in_last;
   logic        in_ready;
   logic        out_ready = 1'b0;
   logic        out_valid;
   data_t       out_data;
   logic        out_last;
   tag_t        out_tag;
   logic        seq_error;
   level_t      fill_level;
   logic [31:0] rnd;
   entry_t      exp_q[$];
   int          ready_mode;
   int          fill_count;
   logic        fill_checked;

   cdc_stream_bridge u_cdc_stream_bridge (.*);

   initial begin
      rclk = 1'b0;
      forever #50 rclk = ~rclk;
   end

   initial begin
      wclk = 1'b0;
      forever #35 wclk = ~wclk;
   end

   task automatic fail_run();
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_tag(input string name, input tag_t got, input tag_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_level(input string name, input level_t got, input level_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   // out_ready changes just after the rclk edge
   initial begin
      void'($urandom(32'hb6a7b25d));
      forever begin
         @(posedge rclk);
         rnd = $urandom;
         #1;
         if (ready_mode == READY_LOW) begin
            out_ready = 1'b0;
         end else if (ready_mode == READY_HIGH) begin
            out_ready = 1'b1;
         end else begin
            out_ready = rnd[0];
         end
      end
   end

   // one word leaves at each edge with out_valid and out_ready high
   always @(posedge rclk) begin
      entry_t exp;
      if (!rst && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("A word came out of the bridge that was never sent");
            fail_run();
         end else begin
            exp = exp_q.pop_front();
            check_data("out_data", out_data, exp[DATA_LSB +: DATA_W]);
            check_flag("out_last", out_last, exp[LAST_POS]);
            check_tag("out_tag", out_tag, exp[TAG_LSB +: TAG_W]);
            check_flag("seq_error", seq_error, 1'b0);
         end
      end
   end

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         if (waited == TIMEOUT_CYCLES) begin
            $display("Timeout: sent words did not all reach the output");
            fail_run();
         end else begin
            @(posedge rclk);
            waited++;
         end
      end
   endtask

   // input stalled with out_ready low, buffer plus consumer hold every word
   task automatic check_fill();
      check_flag("out_valid", out_valid, 1'b1);
      check_count("accepted words", fill_count, DEPTH - 1 + CONSUMER_HELD);
      check_level("fill_level", fill_level, level_t'(DEPTH - 1));
      fill_checked = 1'b1;
      ready_mode   = READY_HIGH;
   endtask

   // holds the word on the input until it is accepted
   task automatic offer_word(input data_t data, input logic last, input logic fill);
      int   waited;
      logic taken;
      waited   = 0;
      taken    = 1'b0;
      in_valid = 1'b1;
      in_data  = data;
      in_last  = last;
      while (!taken) begin
         // full only moves on wclk edges
         taken = in_ready;
         if (!taken && fill && !fill_checked && waited == STALL_CYCLES) begin
            check_fill();
         end
         if (waited == TIMEOUT_CYCLES) begin
            $display("Timeout: in_ready stayed low for an input word");
            fail_run();
         end else begin
            @(posedge wclk);
            #1;
            waited++;
         end
      end
      in_valid = 1'b0;
      if (fill && !fill_checked) begin
         fill_count++;
      end
   endtask

   initial begin
      int          fd;
      int          n;
      int          word_idx;
      string       line;
      logic [31:0] data_v;
      int          last_v;
      int          gap_v;
      int          phase_v;
      logic        fill_started;
      entry_t      exp;
      rst          = 1'b1;
      in_valid     = 1'b0;
      in_data      = '0;
      in_last      = 1'b0;
      ready_mode   = READY_RANDOM;
      fill_count   = 0;
      fill_checked = 1'b0;
      fill_started = 1'b0;
      word_idx     = 0;
      repeat (4) @(posedge rclk);
      #1;
      rst = 1'b0;
      check_level("fill_level", fill_level, '0);
      check_flag("in_ready", in_ready, 1'b1);
      check_flag("out_valid", out_valid, 1'b0);
      @(posedge wclk);
      #1;
      fd = $fopen("bench/stimulus_words.txt", "r");
      if (fd == 0) begin
         $display("Could not open bench/stimulus_words.txt");
         fail_run();
      end
      while ($fgets(line, fd) > 0) begin
         // comment lines do not scan
         n = $sscanf(line, "%h %d %d %d", data_v, last_v, gap_v, phase_v);
         if (n == 4) begin
            if (phase_v != 0 && !fill_started) begin
               // fill starts from an empty bridge
               wait_drained();
               ready_mode   = READY_LOW;
               fill_started = 1'b1;
               repeat (2) @(posedge rclk);
               @(posedge wclk);
               #1;
            end else if (phase_v == 0 && fill_started) begin
               ready_mode = READY_RANDOM;
            end
            repeat (gap_v) begin
               @(posedge wclk);
               #1;
            end
            exp                     = '0;
            exp[TAG_LSB +: TAG_W]   = tag_t'(word_idx % 16);
            exp[LAST_POS]           = (last_v != 0);
            exp[DATA_LSB +: DATA_W] = data_t'(data_v);
            exp_q.push_back(exp);
            word_idx++;
            offer_word(data_t'(data_v), last_v != 0, phase_v != 0);
         end
      end
      $fclose(fd);
      ready_mode = READY_HIGH;
      wait_drained();
      repeat (4) @(posedge rclk);
      #1;
      check_flag("out_valid", out_valid, 1'b0);
      check_level("fill_level", fill_level, '0);
      check_flag("seq_error", seq_error, 1'b0);
      if (!fill_checked) begin
         $display("in_ready never dropped during the fill phase");
         fail_run();
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== cdc_stream_bridge.f ====
hdl/stream_pkg.sv
hdl/fifo_pkg.sv
hdl/gray_ptr.sv
hdl/async_fifo.sv
hdl/word_tagger.sv
hdl/stream_unloader.sv
hdl/cdc_stream_bridge.sv
bench/tb_cdc_stream_bridge.sv

// ==== hdl/async_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module async_fifo (
   input  wire                     rst,
   // write side
   input  wire                     wclk,
   input  wire                     wr_en,
   input  wire stream_pkg::entry_t wr_entry,
   output logic                    full,
   output logic                    wr_accept,
   output fifo_pkg::level_t        level_w,
   // read side
   input  wire                     rclk,
   input  wire                     rd_en,
   output stream_pkg::entry_t      rd_data,
   output logic                    empty,
   output fifo_pkg::level_t        level_r
);
   import stream_pkg::*;
   import fifo_pkg::*;

   entry_t mem [DEPTH];

   // gray pointers and their two-flop copies in the other domain
   ptr_t wptr;
   ptr_t rptr;
   ptr_t rptr_s1;
   ptr_t rptr_s2;
   ptr_t wptr_s1;
   ptr_t wptr_s2;
   logic rd_accept;

   function automatic ptr_t gray_to_bin(input ptr_t g);
      ptr_t b;
      b[ADDR_W-1] = g[ADDR_W-1];
      for (int i = ADDR_W - 2; i >= 0; i--) begin
         b[i] = g[i] ^ b[i+1];
      end
      return b;
   endfunction

   // write domain
   assign wr_accept = wr_en & ~full;

   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         rptr_s1 <= '0;
         rptr_s2 <= '0;
      end else begin
         rptr_s1 <= rptr;
         rptr_s2 <= rptr_s1;
      end
   end

   // memory is addressed by the gray code directly
   always_ff @(posedge wclk) begin
      if (wr_accept) begin
         mem[wptr] <= wr_entry;
      end
   end

   gray_ptr u_wptr (
      .clk_in (wclk),
      .rst    (rst),
      .en     (wr_accept),
      .gray   (wptr)
   );

   assign level_w = level_t'(gray_to_bin(wptr) - gray_to_bin(rptr_s2));
   // one slot stays unused so full and empty differ
   assign full    = (level_w == level_t'(DEPTH - 1));

   // read domain
   assign rd_accept = rd_en & ~empty;

   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         wptr_s1 <= '0;
         wptr_s2 <= '0;
      end else begin
         wptr_s1 <= wptr;
         wptr_s2 <= wptr_s1;
      end
   end

   // registered read, data one cycle after the accepted read
   always_ff @(posedge rclk) begin
      if (rd_accept) begin
         rd_data <= mem[rptr];
      end
   end

   gray_ptr u_rptr (
      .clk_in (rclk),
      .rst    (rst),
      .en     (rd_accept),
      .gray   (rptr)
   );

   assign level_r = level_t'(gray_to_bin(wptr_s2) - gray_to_bin(rptr));
   assign empty   = (level_r == '0);

endmodule

`default_nettype wire

// ==== hdl/cdc_stream_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module cdc_stream_bridge (
   input  wire                    rst,
   input  wire                    wclk,
   input  wire                    rclk,
   // input stream, wclk domain
   input  wire                    in_valid,
   input  wire stream_pkg::data_t in_data,
   input  wire                    in_last,
   output logic                   in_ready,
   // output stream, rclk domain
   input  wire                    out_ready,
   output logic                   out_valid,
   output stream_pkg::data_t      out_data,
   output logic                   out_last,
   output stream_pkg::tag_t       out_tag,
   output logic                   seq_error,
   output fifo_pkg::level_t       fill_level
);
   import stream_pkg::*;

   logic   wr_en;
   logic   wr_accept;
   logic   full;
   entry_t wr_entry;
   logic   rd_en;
   logic   empty;
   entry_t rd_data;

   word_tagger u_word_tagger (
      .rst       (rst),
      .wclk      (wclk),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_last   (in_last),
      .full      (full),
      .wr_accept (wr_accept),
      .in_ready  (in_ready),
      .wr_en     (wr_en),
      .wr_entry  (wr_entry)
   );

   // write-side level only feeds the full flag
   async_fifo u_async_fifo (
      .rst       (rst),
      .wclk      (wclk),
      .wr_en     (wr_en),
      .wr_entry  (wr_entry),
      .full      (full),
      .wr_accept (wr_accept),
      .level_w   (),
      .rclk      (rclk),
      .rd_en     (rd_en),
      .rd_data   (rd_data),
      .empty     (empty),
      .level_r   (fill_level)
   );

   stream_unloader u_stream_unloader (
      .rst       (rst),
      .rclk      (rclk),
      .empty     (empty),
      .rd_data   (rd_data),
      .out_ready (out_ready),
      .rd_en     (rd_en),
      .out_valid (out_valid),
      .out_data  (out_data),
      .out_last  (out_last),
      .out_tag   (out_tag),
      .seq_error (seq_error)
   );

endmodule

`default_nettype wire

// ==== hdl/fifo_pkg.sv ====
`default_nettype none

package fifo_pkg;

   // buffer geometry
   localparam int ADDR_W = 4;
   localparam int DEPTH  = 1 << ADDR_W;

   // gray or binary pointer
   typedef logic [ADDR_W-1:0] ptr_t;

   // fill level, full at DEPTH-1
   typedef logic [ADDR_W-1:0] level_t;

endpackage

`default_nettype wire

// ==== hdl/gray_ptr.sv ====
`timescale 1ns/100ps
`default_nettype none

module gray_ptr (
   input  wire            clk_in,
   input  wire            rst,
   input  wire            en,
   output fifo_pkg::ptr_t gray
);
   import fifo_pkg::*;

   // binary count runs one step ahead of the gray image
   ptr_t bin_cnt;

   always_ff @(posedge clk_in or posedge rst) begin
      if (rst) begin
         bin_cnt <= ptr_t'(1);
         gray    <= '0;
      end else if (en) begin
         // adjacent codes differ in one bit only
         gray    <= bin_cnt ^ (bin_cnt >> 1);
         bin_cnt <= bin_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/stream_pkg.sv ====
`default_nettype none

package stream_pkg;

   // payload and sequence tag widths
   localparam int DATA_W = 8;
   localparam int TAG_W  = 4;

   // entry layout, msb first: tag, last, data
   localparam int ENTRY_W  = TAG_W + 1 + DATA_W;
   localparam int DATA_LSB = 0;
   localparam int LAST_POS = DATA_W;
   localparam int TAG_LSB  = DATA_W + 1;

   typedef logic [DATA_W-1:0] data_t;

   // running sequence number, wraps at 16
   typedef logic [TAG_W-1:0] tag_t;

   typedef logic [ENTRY_W-1:0] entry_t;

endpackage

`default_nettype wire

// ==== hdl/stream_unloader.sv ====
`timescale 1ns/100ps
`default_nettype none

module stream_unloader (
   input  wire                     rst,
   input  wire                     rclk,
   input  wire                     empty,
   input  wire stream_pkg::entry_t rd_data,
   input  wire                     out_ready,
   output logic                    rd_en,
   output logic                    out_valid,
   output stream_pkg::data_t       out_data,
   output logic                    out_last,
   output stream_pkg::tag_t        out_tag,
   output logic                    seq_error
);
   import stream_pkg::*;

   // high in the cycle rd_data carries the word just read
   logic rd_pending;
   tag_t exp_tag;
   tag_t rd_tag;

   assign rd_tag = rd_data[TAG_LSB +: TAG_W];

   // one read in flight, and only into a free or freeing register
   assign rd_en = ~rd_pending & ~empty & (~out_valid | out_ready);

   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         rd_pending <= 1'b0;
         out_valid  <= 1'b0;
         exp_tag    <= '0;
         seq_error  <= 1'b0;
      end else begin
         rd_pending <= rd_en;
         if (rd_pending) begin
            out_valid <= 1'b1;
            exp_tag   <= exp_tag + 1'b1;
            // sticky until reset
            if (rd_tag != exp_tag) begin
               seq_error <= 1'b1;
            end
         end else if (out_valid && out_ready) begin
            out_valid <= 1'b0;
         end
      end
   end

   // output payload
   always_ff @(posedge rclk) begin
      if (rd_pending) begin
         out_data <= rd_data[DATA_LSB +: DATA_W];
         out_last <= rd_data[LAST_POS];
         out_tag  <= rd_tag;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/word_tagger.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_tagger (
   input  wire                    rst,
   input  wire                    wclk,
   input  wire                    in_valid,
   input  wire stream_pkg::data_t in_data,
   input  wire                    in_last,
   input  wire                    full,
   input  wire                    wr_accept,
   output logic                   in_ready,
   output logic                   wr_en,
   output stream_pkg::entry_t     wr_entry
);
   import stream_pkg::*;

   // tag for the next accepted word
   tag_t tag_r;

   assign in_ready = ~full;

   // the fifo qualifies the write with its own full flag
   assign wr_en = in_valid;

   always_comb begin
      wr_entry                       = '0;
      wr_entry[TAG_LSB +: TAG_W]     = tag_r;
      wr_entry[LAST_POS]             = in_last;
      wr_entry[DATA_LSB +: DATA_W]   = in_data;
   end

   // advances only on a stored word, wraps at 16
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         tag_r <= '0;
      end else if (wr_accept) begin
         tag_r <= tag_r + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   --top-module tb_cdc_stream_bridge \
   -f cdc_stream_bridge.f \
   -o sim_cdc_stream_bridge

sim_out=$(./obj_dir/sim_cdc_stream_bridge 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Simulation finished: PASS"; then
   exit 0
fi
exit 1
